//--- sources.f
+incdir+verification
verilog/mips_exc_pkg.sv
verilog/exc_priority.sv
verilog/int_detect.sv
verilog/cp0_regs.sv
verilog/exc_unit_top.sv
verification/tb_exc_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_exc_unit
FILELIST  := sources.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) verification/tb_exc_ref.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_exc_ref.svh
`ifndef TB_EXC_REF_SVH
`define TB_EXC_REF_SVH

// lowest set bit wins, -1 when the word is empty
function automatic int first_flag(input exc_flags_t flags);
    int first;
    first = -1;
    for (int i = EXC_FLAGS - 1; i >= 0; i--) begin
        if (flags[i]) begin
            first = i;
        end
    end
    return first;
endfunction

// pending word is {hw lines, sw bits}, masked by IM and the global enables
function automatic logic int_condition(input logic [7:0] pending, input word_t status);
    cp0_status_u s;
    s.raw = status;
    return (|(pending & s.f.im)) & s.f.ie & ~s.f.exl & ~s.f.erl;
endfunction

function automatic exc_code_t ref_code(input exc_flags_t flags, input logic int_cond);
    exc_code_t code;
    code = CODE_INT;
    if (!int_cond) begin
        case (first_flag(flags))
            FLAG_INSTR:     code = CODE_ADEL;
            FLAG_INSTR_TLB: code = CODE_TLBL;
            FLAG_CPU:       code = CODE_CPU;
            FLAG_RI:        code = CODE_RI;
            FLAG_OF:        code = CODE_OF;
            FLAG_BP:        code = CODE_BP;
            FLAG_SYS:       code = CODE_SYS;
            FLAG_TR:        code = CODE_TR;
            FLAG_LOAD:      code = CODE_ADEL;
            FLAG_SAVE:      code = CODE_ADES;
            FLAG_LOAD_TLB:  code = CODE_TLBL;
            FLAG_SAVE_TLB:  code = CODE_TLBS;
            FLAG_MOD:       code = CODE_MOD;
            default:        code = CODE_INT;
        endcase
    end
    return code;
endfunction

// refill hint only matters when a TLB miss is the chosen flag
function automatic logic refill_hit(input exc_flags_t flags, input logic hint);
    int sel;
    sel = first_flag(flags);
    return hint & ((sel == FLAG_INSTR_TLB) | (sel == FLAG_LOAD_TLB) | (sel == FLAG_SAVE_TLB));
endfunction

function automatic word_t ref_vector(input logic bev, input logic exl, input logic refill);
    logic use_refill;
    use_refill = refill & ~exl;
    if (bev) begin
        return use_refill ? VEC_BEV_REFILL : VEC_BEV_GENERAL;
    end
    return use_refill ? VEC_REFILL : VEC_GENERAL;
endfunction

task automatic check_word(input string name, input word_t actual, input word_t expected);
    n_checks++;
    if (actual !== expected) begin
        n_errors++;
        $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
    end
endtask

task automatic check_code(input string name, input exc_code_t actual, input exc_code_t expected);
    n_checks++;
    if (actual !== expected) begin
        n_errors++;
        $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    n_checks++;
    if (actual !== expected) begin
        n_errors++;
        $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
    end
endtask

`endif

//--- verification/tb_exc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exc_unit
    import mips_exc_pkg::*;
;

    localparam int    N_RANDOM      = 200;
    localparam int    STROBE_COUNT  = N_RANDOM + 120;
    localparam int    WATCHDOG_NS   = (STROBE_COUNT * 10 + 10) * 20;
    localparam word_t STATUS_WMASK  = 32'h0040_ff07;

    logic       clk;
    logic       arst_n;
    logic [5:0] ext_int;
    logic       commit_valid;
    word_t      commit_pc;
    logic       commit_in_delay_slot;
    word_t      commit_vaddr;
    exc_flags_t commit_flags;
    logic       commit_tlb_refill;
    logic       commit_eret;
    logic       cp0_we;
    logic [4:0] cp0_waddr;
    word_t      cp0_wdata;
    logic [4:0] cp0_raddr;
    word_t      cp0_rdata;
    logic       exception_valid;
    exc_code_t  exception_code;
    logic       redirect_valid;
    word_t      redirect_pc;

    int     n_checks;
    int     n_errors;
    integer seed;

    // model state
    logic [5:0] model_meta;
    logic [5:0] m_ip_hw;
    word_t      m_status;
    word_t      m_cause;
    word_t      m_epc;
    word_t      m_badvaddr;
    word_t      nxt_status;
    word_t      nxt_cause;
    word_t      nxt_epc;
    word_t      nxt_badvaddr;

    logic       cur_int;
    logic       cur_refill;
    logic       exp_exc;
    exc_code_t  exp_code;
    logic       exp_redirect_valid;
    word_t      exp_redirect_pc;

    `include "tb_exc_ref.svh"

    exc_unit_top uut (
        .clk                  (clk),
        .arst_n               (arst_n),
        .ext_int              (ext_int),
        .commit_valid         (commit_valid),
        .commit_pc            (commit_pc),
        .commit_in_delay_slot (commit_in_delay_slot),
        .commit_vaddr         (commit_vaddr),
        .commit_flags         (commit_flags),
        .commit_tlb_refill    (commit_tlb_refill),
        .commit_eret          (commit_eret),
        .cp0_we               (cp0_we),
        .cp0_waddr            (cp0_waddr),
        .cp0_wdata            (cp0_wdata),
        .cp0_raddr            (cp0_raddr),
        .cp0_rdata            (cp0_rdata),
        .exception_valid      (exception_valid),
        .exception_code       (exception_code),
        .redirect_valid       (redirect_valid),
        .redirect_pc          (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    // expected response for the current cycle
    always @* begin
        cur_int            = int_condition({m_ip_hw, m_cause[9:8]}, m_status);
        cur_refill         = refill_hit(commit_flags, commit_tlb_refill) & ~cur_int;
        exp_exc            = commit_valid & (cur_int | (|commit_flags));
        exp_code           = ref_code(commit_flags, cur_int);
        exp_redirect_valid = exp_exc | (commit_valid & commit_eret);
        exp_redirect_pc    = exp_exc ? ref_vector(m_status[22], m_status[1], cur_refill) : m_epc;
    end

    function automatic word_t model_read(input logic [4:0] addr);
        case (addr)
            CP0_STATUS:   return m_status;
            CP0_CAUSE:    return {m_cause[31:16], m_ip_hw, m_cause[9:0]};
            CP0_EPC:      return m_epc;
            CP0_BADVADDR: return m_badvaddr;
            default:      return '0;
        endcase
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_meta <= '0;
            m_ip_hw    <= '0;
            m_status   <= STATUS_RESET;
            m_cause    <= '0;
            m_epc      <= '0;
            m_badvaddr <= '0;
        end else begin
            model_meta   <= ext_int;
            m_ip_hw      <= model_meta;
            nxt_status   = m_status;
            nxt_cause    = m_cause;
            nxt_epc      = m_epc;
            nxt_badvaddr = m_badvaddr;
            if (cp0_we) begin
                case (cp0_waddr)
                    CP0_STATUS:   nxt_status = cp0_wdata & STATUS_WMASK;
                    CP0_CAUSE:    nxt_cause[9:8] = cp0_wdata[9:8];
                    CP0_EPC:      nxt_epc = cp0_wdata;
                    CP0_BADVADDR: nxt_badvaddr = cp0_wdata;
                    default:      nxt_epc = m_epc;
                endcase
            end
            if (commit_valid && commit_eret && !exp_exc) begin
                nxt_status[1] = 1'b0;
            end
            if (exp_exc) begin
                if (!m_status[1]) begin
                    nxt_epc       = commit_in_delay_slot ? commit_pc - 32'd4 : commit_pc;
                    nxt_cause[31] = commit_in_delay_slot;
                end
                nxt_status[1]  = 1'b1;
                nxt_cause[6:2] = exp_code;
                if (exp_code inside {CODE_ADEL, CODE_ADES, CODE_TLBL, CODE_TLBS, CODE_MOD}) begin
                    nxt_badvaddr = commit_vaddr;
                end
            end
            m_status   <= nxt_status;
            m_cause    <= nxt_cause;
            m_epc      <= nxt_epc;
            m_badvaddr <= nxt_badvaddr;
        end
    end

    // compare in the middle of each cycle, inputs settle after the rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            check_bit("exception_valid", exception_valid, exp_exc);
            check_bit("redirect_valid", redirect_valid, exp_redirect_valid);
            if (exp_exc) begin
                check_code("exception_code", exception_code, exp_code);
            end
            if (exp_redirect_valid) begin
                check_word("redirect_pc", redirect_pc, exp_redirect_pc);
            end
            check_word("cp0_rdata", cp0_rdata, model_read(cp0_raddr));
        end
    end

    function automatic word_t make_status(input logic bev, input logic [7:0] im,
                                          input logic erl, input logic exl, input logic ie);
        cp0_status_u s;
        s.raw   = '0;
        s.f.bev = bev;
        s.f.im  = im;
        s.f.erl = erl;
        s.f.exl = exl;
        s.f.ie  = ie;
        return s.raw;
    endfunction

    task automatic commit_instr(input exc_flags_t flags, input word_t pc, input logic ds,
                                input word_t vaddr, input logic refill, input logic eret);
        @(posedge clk);
        commit_valid         <= 1'b1;
        commit_flags         <= flags;
        commit_pc            <= pc;
        commit_in_delay_slot <= ds;
        commit_vaddr         <= vaddr;
        commit_tlb_refill    <= refill;
        commit_eret          <= eret;
        @(posedge clk);
        commit_valid         <= 1'b0;
        commit_flags         <= '0;
        commit_tlb_refill    <= 1'b0;
        commit_eret          <= 1'b0;
    endtask

    task automatic write_cp0(input logic [4:0] addr, input word_t data);
        @(posedge clk);
        cp0_we    <= 1'b1;
        cp0_waddr <= addr;
        cp0_wdata <= data;
        @(posedge clk);
        cp0_we    <= 1'b0;
    endtask

    task automatic read_cp0(input logic [4:0] addr, output word_t value);
        @(posedge clk);
        cp0_raddr <= addr;
        @(negedge clk);
        value = cp0_rdata;
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%-18s %s, %0d errors", name,
                 (n_errors == errors_before) ? "passed" : "failed", n_errors - errors_before);
    endtask

    task automatic random_priority();
        word_t r1;
        word_t r2;
        word_t r3;
        for (int n = 0; n < N_RANDOM; n++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            commit_instr(r1[12:0] & r2[12:0] & r3[12:0], {r2[31:2], 2'b00}, r1[31],
                         r3, r1[30], 1'b0);
        end
    endtask

    task automatic vector_sweep();
        for (int k = 0; k < 8; k++) begin
            write_cp0(CP0_STATUS, make_status(k[2], 8'h00, 1'b0, k[1], 1'b0));
            commit_instr(exc_flags_t'(1) << FLAG_LOAD_TLB, 32'h0040_0100, 1'b0,
                         32'h0001_2000, k[0], 1'b0);
        end
    endtask

    task automatic state_update();
        word_t v;
        write_cp0(CP0_STATUS, make_status(1'b0, 8'h00, 1'b0, 1'b0, 1'b0));
        commit_instr(exc_flags_t'(1) << FLAG_LOAD, 32'h0000_1000, 1'b1,
                     32'hdead_beef, 1'b0, 1'b0);
        read_cp0(CP0_EPC, v);
        check_word("epc", v, 32'h0000_0ffc);
        read_cp0(CP0_CAUSE, v);
        check_bit("cause_bd", v[31], 1'b1);
        check_code("cause_exc_code", v[6:2], CODE_ADEL);
        read_cp0(CP0_BADVADDR, v);
        check_word("badvaddr", v, 32'hdead_beef);
        // nested exception while EXL is set
        commit_instr(exc_flags_t'(1) << FLAG_SAVE, 32'h0000_2000, 1'b0,
                     32'h1234_5678, 1'b0, 1'b0);
        read_cp0(CP0_EPC, v);
        check_word("epc", v, 32'h0000_0ffc);
        read_cp0(CP0_CAUSE, v);
        check_code("cause_exc_code", v[6:2], CODE_ADES);
        read_cp0(CP0_BADVADDR, v);
        check_word("badvaddr", v, 32'h1234_5678);
    endtask

    task automatic interrupt_masking();
        word_t v;
        @(posedge clk);
        ext_int <= 6'b10_0101;
        repeat (3) @(posedge clk);
        read_cp0(CP0_CAUSE, v);
        check_word("cause_ip_hw", word_t'(v[15:10]), word_t'(6'b10_0101));
        // IM 0x04 hits ext_int[0], 0x08 hits an idle line
        for (int k = 0; k < 16; k++) begin
            write_cp0(CP0_STATUS, make_status(1'b1, k[3] ? 8'h04 : 8'h08, k[2], k[1], k[0]));
            commit_instr('0, 32'h0000_3000, 1'b0, 32'h0, 1'b0, 1'b0);
            write_cp0(CP0_STATUS, make_status(1'b1, k[3] ? 8'h04 : 8'h08, k[2], k[1], k[0]));
            commit_instr(exc_flags_t'(1) << FLAG_OF, 32'h0000_3004, 1'b0, 32'h0, 1'b0, 1'b0);
        end
        @(posedge clk);
        ext_int <= '0;
        repeat (3) @(posedge clk);
        write_cp0(CP0_CAUSE, 32'h0000_0200);
        for (int k = 0; k < 4; k++) begin
            write_cp0(CP0_STATUS, make_status(1'b1, k[1] ? 8'h02 : 8'h01, 1'b0, 1'b0, k[0]));
            commit_instr('0, 32'h0000_3100, 1'b0, 32'h0, 1'b0, 1'b0);
        end
        write_cp0(CP0_CAUSE, 32'h0);
    endtask

    task automatic eret_return();
        word_t v;
        write_cp0(CP0_STATUS, make_status(1'b0, 8'h00, 1'b0, 1'b0, 1'b0));
        commit_instr(exc_flags_t'(1) << FLAG_SYS, 32'h0000_4000, 1'b0, 32'h0, 1'b0, 1'b0);
        read_cp0(CP0_EPC, v);
        check_word("epc", v, 32'h0000_4000);
        commit_instr('0, 32'h8000_0200, 1'b0, 32'h0, 1'b0, 1'b1);
        read_cp0(CP0_STATUS, v);
        check_bit("status_exl", v[1], 1'b0);
    endtask

    task automatic register_access();
        word_t v;
        write_cp0(CP0_STATUS, 32'hffff_ffff);
        read_cp0(CP0_STATUS, v);
        check_word("status", v, STATUS_WMASK);
        write_cp0(CP0_EPC, 32'h1357_9bdf);
        read_cp0(CP0_EPC, v);
        check_word("epc", v, 32'h1357_9bdf);
        write_cp0(CP0_BADVADDR, 32'h2468_ace0);
        read_cp0(CP0_BADVADDR, v);
        check_word("badvaddr", v, 32'h2468_ace0);
    endtask

    initial begin
        int errors_before;
        seed                 = 32'hc715;
        n_checks             = 0;
        n_errors             = 0;
        arst_n               = 1'b0;
        ext_int              = '0;
        commit_valid         = 1'b0;
        commit_pc            = '0;
        commit_in_delay_slot = 1'b0;
        commit_vaddr         = '0;
        commit_flags         = '0;
        commit_tlb_refill    = 1'b0;
        commit_eret          = 1'b0;
        cp0_we               = 1'b0;
        cp0_waddr            = '0;
        cp0_wdata            = '0;
        cp0_raddr            = CP0_STATUS;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        errors_before = n_errors;
        random_priority();
        report_test("priority", errors_before);
        errors_before = n_errors;
        vector_sweep();
        report_test("vectors", errors_before);
        errors_before = n_errors;
        state_update();
        report_test("state update", errors_before);
        errors_before = n_errors;
        interrupt_masking();
        report_test("interrupt masking", errors_before);
        errors_before = n_errors;
        eret_return();
        report_test("eret", errors_before);
        errors_before = n_errors;
        register_access();
        report_test("register access", errors_before);

        @(posedge clk);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/exc_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module exc_unit_top
    import mips_exc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [5:0] ext_int,
    input  logic       commit_valid,
    input  word_t      commit_pc,
    input  logic       commit_in_delay_slot,
    input  word_t      commit_vaddr,
    input  exc_flags_t commit_flags,
    input  logic       commit_tlb_refill,
    input  logic       commit_eret,
    input  logic       cp0_we,
    input  logic [4:0] cp0_waddr,
    input  word_t      cp0_wdata,
    input  logic [4:0] cp0_raddr,
    output word_t      cp0_rdata,
    output logic       exception_valid,
    output exc_code_t  exception_code,
    output logic       redirect_valid,
    output word_t      redirect_pc
);

    logic       flag_any;
    exc_code_t  flag_code;
    logic       flag_refill;
    logic       int_taken;
    logic [5:0] ip_hw;
    logic [7:0] status_im;
    logic       status_ie;
    logic       status_exl;
    logic       status_erl;
    logic [1:0] ip_sw;

    exc_priority u_exc_priority (
        .flags       (commit_flags),
        .tlb_refill  (commit_tlb_refill),
        .flag_any    (flag_any),
        .flag_code   (flag_code),
        .flag_refill (flag_refill)
    );

    // Status inputs come from registers, so no loop back through cp0_regs
    int_detect u_int_detect (
        .clk        (clk),
        .arst_n     (arst_n),
        .ext_int    (ext_int),
        .ip_sw      (ip_sw),
        .status_im  (status_im),
        .status_ie  (status_ie),
        .status_exl (status_exl),
        .status_erl (status_erl),
        .ip_hw      (ip_hw),
        .int_taken  (int_taken)
    );

    cp0_regs u_cp0_regs (
        .clk                  (clk),
        .arst_n               (arst_n),
        .commit_valid         (commit_valid),
        .commit_pc            (commit_pc),
        .commit_in_delay_slot (commit_in_delay_slot),
        .commit_vaddr         (commit_vaddr),
        .commit_eret          (commit_eret),
        .flag_any             (flag_any),
        .flag_code            (flag_code),
        .flag_refill          (flag_refill),
        .int_taken            (int_taken),
        .ip_hw                (ip_hw),
        .cp0_we               (cp0_we),
        .cp0_waddr            (cp0_waddr),
        .cp0_wdata            (cp0_wdata),
        .cp0_raddr            (cp0_raddr),
        .cp0_rdata            (cp0_rdata),
        .exception_valid      (exception_valid),
        .exception_code       (exception_code),
        .redirect_valid       (redirect_valid),
        .redirect_pc          (redirect_pc),
        .status_im            (status_im),
        .status_ie            (status_ie),
        .status_exl           (status_exl),
        .status_erl           (status_erl),
        .ip_sw                (ip_sw)
    );

endmodule

`default_nettype wire

//--- verilog/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs
    import mips_exc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       commit_valid,
    input  word_t      commit_pc,
    input  logic       commit_in_delay_slot,
    input  word_t      commit_vaddr,
    input  logic       commit_eret,
    input  logic       flag_any,
    input  exc_code_t  flag_code,
    input  logic       flag_refill,
    input  logic       int_taken,
    input  logic [5:0] ip_hw,
    input  logic       cp0_we,
    input  logic [4:0] cp0_waddr,
    input  word_t      cp0_wdata,
    input  logic [4:0] cp0_raddr,
    output word_t      cp0_rdata,
    output logic       exception_valid,
    output exc_code_t  exception_code,
    output logic       redirect_valid,
    output word_t      redirect_pc,
    output logic [7:0] status_im,
    output logic       status_ie,
    output logic       status_exl,
    output logic       status_erl,
    output logic [1:0] ip_sw
);

    cp0_status_u status_q;
    cp0_status_u status_d;
    cp0_status_u wdata_u;
    word_t       cause_q;
    word_t       cause_d;
    word_t       cause_rd;
    word_t       epc_q;
    word_t       epc_d;
    word_t       badvaddr_q;
    word_t       badvaddr_d;

    logic        exc_take;
    logic        eret_take;
    logic        refill_eff;
    logic        addr_exc;
    exc_code_t   code_sel;
    word_t       vector;
    word_t       epc_new;

    assign exc_take  = commit_valid & (int_taken | flag_any);
    assign eret_take = commit_valid & commit_eret & ~exc_take;

    // interrupt wins over any flag
    assign code_sel = int_taken ? CODE_INT : flag_code;

    // nested misses go to the general vector
    assign refill_eff = flag_refill & ~int_taken & ~status_q.f.exl;

    always_comb begin
        if (status_q.f.bev) begin
            vector = refill_eff ? VEC_BEV_REFILL : VEC_BEV_GENERAL;
        end else begin
            vector = refill_eff ? VEC_REFILL : VEC_GENERAL;
        end
    end

    // codes that latch the faulting address
    assign addr_exc = (code_sel == CODE_ADEL) | (code_sel == CODE_ADES) |
                      (code_sel == CODE_TLBL) | (code_sel == CODE_TLBS) |
                      (code_sel == CODE_MOD);

    // restart at the branch when the fault is in its delay slot
    assign epc_new = commit_in_delay_slot ? (commit_pc - 32'd4) : commit_pc;

    assign exception_valid = exc_take;
    assign exception_code  = code_sel;
    assign redirect_valid  = exc_take | eret_take;
    assign redirect_pc     = exc_take ? vector : epc_q;

    assign wdata_u.raw = cp0_wdata;

    always_comb begin
        status_d   = status_q;
        cause_d    = cause_q;
        epc_d      = epc_q;
        badvaddr_d = badvaddr_q;

        // software port first, exception update below overrides it
        if (cp0_we) begin
            case (cp0_waddr)
                CP0_STATUS: begin
                    status_d.f.bev = wdata_u.f.bev;
                    status_d.f.im  = wdata_u.f.im;
                    status_d.f.erl = wdata_u.f.erl;
                    status_d.f.exl = wdata_u.f.exl;
                    status_d.f.ie  = wdata_u.f.ie;
                end
                CP0_CAUSE: begin
                    cause_d[CAUSE_IP_LO +: 2] = cp0_wdata[CAUSE_IP_LO +: 2];
                end
                CP0_EPC: begin
                    epc_d = cp0_wdata;
                end
                CP0_BADVADDR: begin
                    badvaddr_d = cp0_wdata;
                end
                default: begin
                    status_d = status_q;
                end
            endcase
        end

        if (eret_take) begin
            status_d.f.exl = 1'b0;
        end

        if (exc_take) begin
            status_d.f.exl = 1'b1;
            // EPC and BD only captured on the first level
            if (!status_q.f.exl) begin
                epc_d             = epc_new;
                cause_d[CAUSE_BD] = commit_in_delay_slot;
            end
            cause_d[CAUSE_EXC_HI:CAUSE_EXC_LO] = code_sel;
            if (addr_exc) begin
                badvaddr_d = commit_vaddr;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_q.raw <= STATUS_RESET;
            cause_q      <= '0;
            epc_q        <= '0;
            badvaddr_q   <= '0;
        end else begin
            status_q   <= status_d;
            cause_q    <= cause_d;
            epc_q      <= epc_d;
            badvaddr_q <= badvaddr_d;
        end
    end

    // hardware pending bits are live, not stored
    always_comb begin
        cause_rd = cause_q;
        cause_rd[CAUSE_IP_HI:CAUSE_IP_LO+2] = ip_hw;
    end

    always_comb begin
        case (cp0_raddr)
            CP0_STATUS:   cp0_rdata = status_q.raw;
            CP0_CAUSE:    cp0_rdata = cause_rd;
            CP0_EPC:      cp0_rdata = epc_q;
            CP0_BADVADDR: cp0_rdata = badvaddr_q;
            default:      cp0_rdata = '0;
        endcase
    end

    assign status_im  = status_q.f.im;
    assign status_ie  = status_q.f.ie;
    assign status_exl = status_q.f.exl;
    assign status_erl = status_q.f.erl;
    assign ip_sw      = cause_q[CAUSE_IP_LO +: 2];

endmodule

`default_nettype wire

//--- verilog/int_detect.sv
`timescale 1ns/1ps
`default_nettype none

module int_detect
    import mips_exc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [5:0] ext_int,
    input  logic [1:0] ip_sw,
    input  logic [7:0] status_im,
    input  logic       status_ie,
    input  logic       status_exl,
    input  logic       status_erl,
    output logic [5:0] ip_hw,
    output logic       int_taken
);

    logic [5:0] ext_meta;
    logic [5:0] ext_sync;
    logic [7:0] pending;
    logic       int_enabled;

    // two-flop synchronizer, lines are asynchronous to clk
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ext_meta <= '0;
            ext_sync <= '0;
        end else begin
            ext_meta <= ext_int;
            ext_sync <= ext_meta;
        end
    end

    assign ip_hw = ext_sync;

    // hardware lines sit above the two software bits, as in Cause.IP
    assign pending = {ip_hw, ip_sw};

    // global enable, blocked while in exception or error level
    assign int_enabled = status_ie & ~status_exl & ~status_erl;

    assign int_taken = (|(pending & status_im)) & int_enabled;

endmodule

`default_nettype wire

//--- verilog/exc_priority.sv
`timescale 1ns/1ps
`default_nettype none

module exc_priority
    import mips_exc_pkg::*;
(
    input  exc_flags_t flags,
    input  logic       tlb_refill,
    output logic       flag_any,
    output exc_code_t  flag_code,
    output logic       flag_refill
);

    // selected flag is one of the TLB ones
    logic sel_tlb;

    always_comb begin
        flag_code = CODE_INT;
        sel_tlb   = 1'b0;
        priority case (1'b1)
            flags[FLAG_INSTR]: begin
                flag_code = CODE_ADEL;
            end
            flags[FLAG_INSTR_TLB]: begin
                flag_code = CODE_TLBL;
                sel_tlb   = 1'b1;
            end
            flags[FLAG_CPU]: begin
                flag_code = CODE_CPU;
            end
            flags[FLAG_RI]: begin
                flag_code = CODE_RI;
            end
            flags[FLAG_OF]: begin
                flag_code = CODE_OF;
            end
            flags[FLAG_BP]: begin
                flag_code = CODE_BP;
            end
            flags[FLAG_SYS]: begin
                flag_code = CODE_SYS;
            end
            flags[FLAG_TR]: begin
                flag_code = CODE_TR;
            end
            flags[FLAG_LOAD]: begin
                flag_code = CODE_ADEL;
            end
            flags[FLAG_SAVE]: begin
                flag_code = CODE_ADES;
            end
            flags[FLAG_LOAD_TLB]: begin
                flag_code = CODE_TLBL;
                sel_tlb   = 1'b1;
            end
            flags[FLAG_SAVE_TLB]: begin
                flag_code = CODE_TLBS;
                sel_tlb   = 1'b1;
            end
            flags[FLAG_MOD]: begin
                flag_code = CODE_MOD;
            end
            default: begin
                // no flag set, code is don't-care upstream
                flag_code = CODE_INT;
                sel_tlb   = 1'b0;
            end
        endcase
    end

    assign flag_any = |flags;

    // refill hint only counts for the selected TLB miss
    assign flag_refill = sel_tlb & tlb_refill;

endmodule

`default_nettype wire

//--- verilog/mips_exc_pkg.sv
`default_nettype none

package mips_exc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  exc_code_t;

    // MIPS32 Cause.ExcCode values
    localparam exc_code_t CODE_INT  = 5'd0;
    localparam exc_code_t CODE_MOD  = 5'd1;
    localparam exc_code_t CODE_TLBL = 5'd2;
    localparam exc_code_t CODE_TLBS = 5'd3;
    localparam exc_code_t CODE_ADEL = 5'd4;
    localparam exc_code_t CODE_ADES = 5'd5;
    localparam exc_code_t CODE_SYS  = 5'd8;
    localparam exc_code_t CODE_BP   = 5'd9;
    localparam exc_code_t CODE_RI   = 5'd10;
    localparam exc_code_t CODE_CPU  = 5'd11;
    localparam exc_code_t CODE_OF   = 5'd12;
    localparam exc_code_t CODE_TR   = 5'd13;

    localparam int EXC_FLAGS = 13;

    // flag bit positions, highest priority first
    localparam int FLAG_INSTR     = 0;
    localparam int FLAG_INSTR_TLB = 1;
    localparam int FLAG_CPU       = 2;
    localparam int FLAG_RI        = 3;
    localparam int FLAG_OF        = 4;
    localparam int FLAG_BP        = 5;
    localparam int FLAG_SYS       = 6;
    localparam int FLAG_TR        = 7;
    localparam int FLAG_LOAD      = 8;
    localparam int FLAG_SAVE      = 9;
    localparam int FLAG_LOAD_TLB  = 10;
    localparam int FLAG_SAVE_TLB  = 11;
    localparam int FLAG_MOD       = 12;

    typedef logic [EXC_FLAGS-1:0] exc_flags_t;

    // CP0 register numbers
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    // exception entry points
    localparam word_t VEC_BEV_REFILL  = 32'hbfc0_0200;
    localparam word_t VEC_BEV_GENERAL = 32'hbfc0_0380;
    localparam word_t VEC_REFILL      = 32'h8000_0000;
    localparam word_t VEC_GENERAL     = 32'h8000_0180;

    // only BEV set out of reset
    localparam word_t STATUS_RESET = 32'h0040_0000;

    typedef struct packed {
        logic [8:0] rsv_31_23;
        logic       bev;
        logic [5:0] rsv_21_16;
        logic [7:0] im;
        logic [4:0] rsv_7_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } cp0_status_t;

    typedef union packed {
        word_t       raw;
        cp0_status_t f;
    } cp0_status_u;

    // Cause field positions
    localparam int CAUSE_BD     = 31;
    localparam int CAUSE_IP_HI  = 15;
    localparam int CAUSE_IP_LO  = 8;
    localparam int CAUSE_EXC_HI = 6;
    localparam int CAUSE_EXC_LO = 2;

endpackage

`default_nettype wire
